//--- project.f
+incdir+hdl
hdl/pov_pkg.sv
hdl/hall_sensor.sv
hdl/pov_config.sv
hdl/column_mem.sv
hdl/slice_fetch.sv
hdl/led_shifter.sv
hdl/pov_display_top.sv
testbench/tb_pov_display.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_pov_display
FILELIST = project.f

BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# The run passes only if the log holds the pass message
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(TOOL) --lint-only --timing -Wall -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/tb_pov_display.sv
`timescale 1ns/10ps
`default_nettype none

`include "pov_defines.svh"

module tb_pov_display;

    import pov_pkg::*;

    localparam int CLK_HALF     = 4;
    localparam int RESET_CYCLES = 3;
    localparam int MEM_DEPTH    = 2 * `POV_SLICES_HALF;
    // Playback runs at 40 cycles per slice and back-pressure at 8
    localparam int HALF_PLAY    = `POV_SLICES_HALF * 40;
    localparam int HALF_GUARD   = 6000;
    localparam int HALF_FAST    = `POV_SLICES_HALF * 8;
    localparam int LOW_SHORT    = 4;
    localparam int LOW_LONG     = 600;
    localparam int MARGIN       = 2000;
    // One calibration and two playback half turns, the guard test and four fast ones
    localparam int RUN_CYCLES   = RESET_CYCLES + MEM_DEPTH + 3 * HALF_PLAY + HALF_GUARD
                                  + 4 * HALF_FAST + MARGIN;

    logic        clk;
    logic        nrst;
    logic        hall_1;
    logic        hall_2;
    logic        reg_wr;
    reg_addr_t   reg_addr;
    reg_data_t   reg_wdata;
    logic        mem_wr;
    slice_t      mem_addr;
    column_t     mem_wdata;
    reg_data_t   reg_rdata;
    logic        led_sdo;
    logic        led_sck;
    logic        led_latch;

    // Copy of the image and the columns the next latches must show
    column_t     mem_copy [MEM_DEPTH];
    column_t     expect_q [$];
    logic [31:0] rng_state;
    string       test_name;
    logic        check_cols;
    column_t     rx_col;
    int          rx_bits;
    int          latch_cnt;
    int          mismatch_errs;
    int          other_errs;

    pov_display_top dut (
        .clk       (clk),
        .nrst      (nrst),
        .hall_1    (hall_1),
        .hall_2    (hall_2),
        .reg_wr    (reg_wr),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .mem_wr    (mem_wr),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .reg_rdata (reg_rdata),
        .led_sdo   (led_sdo),
        .led_sck   (led_sck),
        .led_latch (led_latch)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // Watchdog sized from the sum of all half turns
    initial begin
        repeat (RUN_CYCLES) @(posedge clk);
        other_errs = other_errs + 1;
        $display("Timeout, the test sequence did not finish within %0d cycles", RUN_CYCLES);
        $display("Errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
        $display("CHECKS FAILED");
        $finish;
    end

    function automatic void report_mismatch(input string name, input logic [31:0] exp,
                                            input logic [31:0] got);
        mismatch_errs = mismatch_errs + 1;
        $display("MISMATCH %s expected %0h actual %0h", name, exp, got);
    endfunction

    function automatic void report_failure(input string msg);
        other_errs = other_errs + 1;
        $display("ERROR %s", msg);
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Speed is the clock rate over two half turns of N + 1 cycles
    function automatic reg_data_t speed_for(input int n);
        logic [31:0] q;
        q = `POV_CLOCK_HZ / (2 * (n + 1));
        return reg_data_t'(q);
    endfunction

    // Syncs in a half turn of len cycles when the one before lasted prev_len
    // Sync j is decided C * j + 1 cycles after the sensor edge and must come before the next edge
    function automatic int slices_in_half(input int prev_len, input int len);
        int period;
        int n;
        period = prev_len / `POV_SLICES_HALF;
        if (period == 0) begin
            return 1;
        end
        n = 1 + (len - 2) / period;
        return (n > `POV_SLICES_HALF) ? `POV_SLICES_HALF : n;
    endfunction

    function automatic void expect_columns(input int base, input int count, input int offset);
        for (int j = 0; j < count; j++) begin
            expect_q.push_back(mem_copy[(base + j + offset) % MEM_DEPTH]);
        end
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        next_cycle();
        reg_wr = 1'b0;
    endtask

    // Read data is combinational, so it is taken in the middle of the cycle
    task automatic read_reg(input reg_addr_t addr, output reg_data_t data);
        reg_addr = addr;
        #2;
        data = reg_rdata;
        next_cycle();
    endtask

    task automatic check_reg(input string name, input reg_addr_t addr, input reg_data_t exp);
        reg_data_t got;
        read_reg(addr, got);
        assert (got == exp) else report_mismatch(name, 32'(exp), 32'(got));
    endtask

    task automatic fill_memory();
        mem_wr = 1'b1;
        for (int a = 0; a < MEM_DEPTH; a++) begin
            rng_state   = xorshift32(rng_state);
            mem_addr    = slice_t'(a);
            mem_wdata   = column_t'(rng_state);
            mem_copy[a] = column_t'(rng_state);
            next_cycle();
        end
        mem_wr = 1'b0;
    endtask

    // Pulls one sensor low for low_len cycles within a half turn of len cycles
    task automatic half_turn(input int sensor, input int len, input int low_len);
        if (sensor == 1) begin
            hall_1 = 1'b0;
        end else begin
            hall_2 = 1'b0;
        end
        repeat (low_len) next_cycle();
        hall_1 = 1'b1;
        hall_2 = 1'b1;
        repeat (len - low_len) next_cycle();
    endtask

    task automatic check_half_done(input int first_latch, input int exp_latches);
        assert (expect_q.size() == 0)
            else report_failure({test_name, ": some expected columns were never latched"});
        assert (latch_cnt - first_latch == exp_latches)
            else report_mismatch({test_name, "_latches"}, exp_latches, latch_cnt - first_latch);
        expect_q.delete();
    endtask

    // LED deserializer sampling the data bit as the shift clock rises
    always @(posedge led_sck) begin
        rx_col  = {rx_col[$bits(column_t)-2:0], led_sdo};
        rx_bits = rx_bits + 1;
    end

    always @(posedge led_latch) begin
        column_t exp_col;
        latch_cnt = latch_cnt + 1;
        assert (rx_bits == `POV_NUM_LEDS)
            else report_failure($sformatf("latch came after %0d shifted bits", rx_bits));
        if (check_cols) begin
            if (expect_q.size() == 0) begin
                report_failure({test_name, ": a column was latched when none was expected"});
            end else begin
                exp_col = expect_q.pop_front();
                assert (rx_col == exp_col) else report_mismatch(test_name, exp_col, rx_col);
            end
        end
        rx_bits = 0;
    end

    a_latch_single : assert property (
        @(posedge clk) disable iff (!nrst) led_latch |=> !led_latch
    ) else report_failure("led_latch stayed high for more than one cycle");

    a_latch_not_clocked : assert property (
        @(posedge clk) disable iff (!nrst) !(led_latch && led_sck)
    ) else report_failure("led_sck was high during led_latch");

    initial begin
        int        syncs;
        int        first_latch;
        int        latch_base;
        reg_data_t dropped_now;
        reg_data_t dropped_end;

        nrst          = 1'b0;
        hall_1        = 1'b1;
        hall_2        = 1'b1;
        reg_wr        = 1'b0;
        reg_addr      = '0;
        reg_wdata     = '0;
        mem_wr        = 1'b0;
        mem_addr      = '0;
        mem_wdata     = '0;
        rng_state     = 32'h7009_222f;
        test_name     = "reset";
        check_cols    = 1'b0;
        rx_col        = '0;
        rx_bits       = 0;
        latch_cnt     = 0;
        mismatch_errs = 0;
        other_errs    = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        nrst = 1'b1;

        check_reg("reset_ctrl", `POV_REG_CTRL, 16'd0);
        check_reg("reset_offset", `POV_REG_OFFSET, 16'd0);
        check_reg("reset_dropped", `POV_REG_DROPPED, 16'd0);
        check_reg("reset_speed", `POV_REG_SPEED, 16'd0);
        fill_memory();

        // The first half turn only sets the slice period, output is still disabled
        test_name = "calibration";
        half_turn(1, HALF_PLAY, LOW_SHORT);

        // Register writes share the cycles of the sensor pulse and land before the first sync
        test_name  = "playback_offset_0";
        check_cols = 1'b1;
        syncs      = slices_in_half(HALF_PLAY, HALF_PLAY);
        expect_columns(0, syncs, 0);
        first_latch = latch_cnt;
        fork
            half_turn(1, HALF_PLAY, LOW_SHORT);
            begin
                reg_write(`POV_REG_OFFSET, 16'd0);
                reg_write(`POV_REG_CTRL, 16'd1);
            end
        join
        check_half_done(first_latch, syncs);

        // hall_2 starts the second half at slice 128
        test_name = "playback_offset_37";
        syncs     = slices_in_half(HALF_PLAY, HALF_PLAY);
        expect_columns(`POV_SLICES_HALF, syncs, 37);
        first_latch = latch_cnt;
        fork
            half_turn(2, HALF_PLAY, LOW_SHORT);
            begin
                reg_write(`POV_REG_OFFSET, 16'd37);
                repeat (8) next_cycle();
                check_reg("speed_after_5120", `POV_REG_SPEED, speed_for(HALF_PLAY));
            end
        join
        check_half_done(first_latch, syncs);

        // A long low pulse must give one top and one unbroken slice sequence
        test_name = "guard_long_low";
        syncs     = slices_in_half(HALF_PLAY, HALF_GUARD);
        expect_columns(0, syncs, 37);
        first_latch = latch_cnt;
        half_turn(1, HALF_GUARD, LOW_LONG);
        check_half_done(first_latch, syncs);

        // Disabled half turn that brings the slice period down to 8 cycles
        test_name  = "backpressure";
        check_cols = 1'b0;
        fork
            half_turn(2, HALF_FAST, LOW_SHORT);
            begin
                reg_write(`POV_REG_CTRL, 16'd0);
                repeat (8) next_cycle();
                check_reg("speed_after_6000", `POV_REG_SPEED, speed_for(HALF_GUARD));
            end
        join

        // Slices now come every 8 cycles against a 33-cycle column
        syncs      = slices_in_half(HALF_FAST, HALF_FAST);
        latch_base = latch_cnt;
        fork
            half_turn(1, HALF_FAST, LOW_SHORT);
            begin
                reg_write(`POV_REG_CTRL, 16'd1);
                repeat (8) next_cycle();
                check_reg("speed_after_1024", `POV_REG_SPEED, speed_for(HALF_FAST));
            end
        join

        // Columns already pushed drain out while output is disabled
        fork
            half_turn(2, HALF_FAST, LOW_SHORT);
            reg_write(`POV_REG_CTRL, 16'd0);
        join

        test_name = "enable_off";
        fork
            half_turn(1, HALF_FAST, LOW_SHORT);
            begin
                read_reg(`POV_REG_DROPPED, dropped_now);
                assert (32'(dropped_now) + 32'(latch_cnt - latch_base) == 32'(syncs))
                    else report_mismatch("backpressure_total", syncs,
                                         32'(dropped_now) + 32'(latch_cnt - latch_base));
                assert (dropped_now != '0)
                    else report_failure("backpressure: no slice was dropped");
                first_latch = latch_cnt;
            end
        join
        read_reg(`POV_REG_DROPPED, dropped_end);
        assert (dropped_end == dropped_now)
            else report_mismatch("enable_off_dropped", 32'(dropped_now), 32'(dropped_end));
        assert (latch_cnt == first_latch)
            else report_mismatch("enable_off_latches", first_latch, latch_cnt);

        // Any write to the dropped register clears it
        test_name = "dropped_clear";
        reg_write(`POV_REG_DROPPED, 16'hffff);
        check_reg("dropped_clear", `POV_REG_DROPPED, 16'd0);

        $display("Errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
        if (mismatch_errs == 0 && other_errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/pov_display_top.sv
`timescale 1ns/10ps
`default_nettype none

module pov_display_top (
    input  wire                     clk,
    input  wire                     nrst,
    input  wire                     hall_1,
    input  wire                     hall_2,
    input  wire                     reg_wr,
    input  wire pov_pkg::reg_addr_t reg_addr,
    input  wire pov_pkg::reg_data_t reg_wdata,
    input  wire                     mem_wr,
    input  wire pov_pkg::slice_t    mem_addr,
    input  wire pov_pkg::column_t   mem_wdata,
    output pov_pkg::reg_data_t      reg_rdata,
    output logic                    led_sdo,
    output logic                    led_sck,
    output logic                    led_latch
);

    import pov_pkg::*;

    // Sensor side
    slice_t    slice_cnt;
    logic      position_sync;
    reg_data_t speed_data;

    // Register side
    logic      enable;
    slice_t    slice_offset;
    logic      drop;

    // Memory read path
    logic      rd_en;
    slice_t    rd_addr;
    column_t   rd_data;

    // Column handshake to the shifter
    logic      col_valid;
    column_t   col_data;
    logic      credit;

    hall_sensor u_hall_sensor (
        .clk           (clk),
        .nrst          (nrst),
        .hall_1        (hall_1),
        .hall_2        (hall_2),
        .slice_cnt     (slice_cnt),
        .position_sync (position_sync),
        .speed_data    (speed_data)
    );

    pov_config u_pov_config (
        .clk          (clk),
        .nrst         (nrst),
        .reg_wr       (reg_wr),
        .reg_addr     (reg_addr),
        .reg_wdata    (reg_wdata),
        .drop         (drop),
        .speed_data   (speed_data),
        .reg_rdata    (reg_rdata),
        .enable       (enable),
        .slice_offset (slice_offset)
    );

    column_mem u_column_mem (
        .clk       (clk),
        .mem_wr    (mem_wr),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    slice_fetch u_slice_fetch (
        .clk           (clk),
        .nrst          (nrst),
        .position_sync (position_sync),
        .slice_cnt     (slice_cnt),
        .enable        (enable),
        .slice_offset  (slice_offset),
        .rd_data       (rd_data),
        .credit        (credit),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .col_valid     (col_valid),
        .col_data      (col_data),
        .drop          (drop)
    );

    led_shifter u_led_shifter (
        .clk       (clk),
        .nrst      (nrst),
        .col_valid (col_valid),
        .col_data  (col_data),
        .credit    (credit),
        .led_sdo   (led_sdo),
        .led_sck   (led_sck),
        .led_latch (led_latch)
    );

endmodule

`default_nettype wire

//--- hdl/led_shifter.sv
`timescale 1ns/10ps
`default_nettype none

`include "pov_defines.svh"

module led_shifter (
    input  wire                   clk,
    input  wire                   nrst,
    input  wire                   col_valid,
    input  wire pov_pkg::column_t col_data,
    output logic                  credit,
    output logic                  led_sdo,
    output logic                  led_sck,
    output logic                  led_latch
);

    import pov_pkg::*;

    localparam int DEPTH    = `POV_FIFO_DEPTH;
    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);
    localparam int BIT_BITS = $clog2(`POV_NUM_LEDS);

    // The latch cycle may also pop the next column
    typedef enum logic [1:0] {ST_IDLE, ST_SHIFT, ST_LATCH} shift_state_t;

    column_t             fifo_mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] fifo_cnt;
    logic                pop;
    shift_state_t        state;
    column_t             shift_reg;
    logic [BIT_BITS-1:0] bit_cnt;
    logic                phase;

    assign pop = (state != ST_SHIFT) && (fifo_cnt != '0);

    // FIFO storage without reset
    always_ff @(posedge clk) begin
        if (col_valid) begin
            fifo_mem[wr_ptr] <= col_data;
        end
    end

    // FIFO pointers and fill level
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_cnt <= '0;
        end else begin
            if (col_valid) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({col_valid, pop})
                2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
                2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
                default: fifo_cnt <= fifo_cnt;
            endcase
        end
    end

    // Serializer FSM with two cycles per bit
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state   <= ST_IDLE;
            bit_cnt <= '0;
            phase   <= 1'b0;
        end else begin
            case (state)
                ST_SHIFT: begin
                    phase <= ~phase;
                    if (phase) begin
                        if (bit_cnt == BIT_BITS'(`POV_NUM_LEDS - 1)) begin
                            state <= ST_LATCH;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    if (pop) begin
                        state   <= ST_SHIFT;
                        bit_cnt <= '0;
                        phase   <= 1'b0;
                    end else begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // Column shift register, MSB first, advanced after the high clock phase
    always_ff @(posedge clk) begin
        if (pop) begin
            shift_reg <= fifo_mem[rd_ptr];
        end else if (state == ST_SHIFT && phase) begin
            shift_reg <= {shift_reg[$bits(column_t)-2:0], 1'b0};
        end
    end

    assign led_sdo   = shift_reg[$bits(column_t)-1];
    assign led_sck   = (state == ST_SHIFT) && phase;
    assign led_latch = (state == ST_LATCH);
    // The column is done, so its slot is handed back in the latch cycle
    assign credit    = (state == ST_LATCH);

    // Credit flow control upstream must keep the FIFO from overflowing
    a_no_push_when_full : assert property (
        @(posedge clk) disable iff (!nrst) col_valid |-> fifo_cnt != CNT_BITS'(DEPTH)
    );

endmodule

`default_nettype wire

//--- hdl/slice_fetch.sv
`timescale 1ns/10ps
`default_nettype none

`include "pov_defines.svh"

module slice_fetch (
    input  wire                   clk,
    input  wire                   nrst,
    input  wire                   position_sync,
    input  wire pov_pkg::slice_t  slice_cnt,
    input  wire                   enable,
    input  wire pov_pkg::slice_t  slice_offset,
    input  wire pov_pkg::column_t rd_data,
    input  wire                   credit,
    output logic                  rd_en,
    output pov_pkg::slice_t       rd_addr,
    output logic                  col_valid,
    output pov_pkg::column_t      col_data,
    output logic                  drop
);

    import pov_pkg::*;

    localparam int DEPTH = `POV_FIFO_DEPTH;
    localparam int CW    = $clog2(DEPTH + 1);

    logic [CW-1:0] credit_cnt;
    // Pushes already decided but not yet taken off the credit count
    logic [CW:0]   in_flight;
    logic          grant;
    slice_t        rot_addr;

    // Rotation by the programmed offset wraps around the full turn
    assign rot_addr = slice_cnt + slice_offset;

    // A read in progress and a push in this cycle both still hold a credit
    assign in_flight = (CW + 1)'(rd_en) + (CW + 1)'(col_valid);
    assign grant     = ({1'b0, credit_cnt} > in_flight);

    // Read request or drop in the cycle after the sync
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            rd_en <= 1'b0;
            drop  <= 1'b0;
        end else begin
            rd_en <= position_sync & enable & grant;
            drop  <= position_sync & enable & ~grant;
        end
    end

    // Read address is only loaded on a sync
    always_ff @(posedge clk) begin
        if (position_sync) begin
            rd_addr <= rot_addr;
        end
    end

    // Push follows the read by one cycle, when the memory data arrives
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            col_valid <= 1'b0;
        end else begin
            col_valid <= rd_en;
        end
    end

    // Memory output register holds the column during the push cycle
    assign col_data = rd_data;

    // Credit counter
    // A push and a returned credit in one cycle cancel out
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            credit_cnt <= CW'(DEPTH);
        end else begin
            case ({col_valid, credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // The shifter never returns more credits than it was given
    a_credit_bound : assert property (
        @(posedge clk) disable iff (!nrst) credit_cnt <= CW'(DEPTH)
    );

    // Every push must be covered by a credit taken at the sync two cycles earlier
    a_push_has_credit : assert property (
        @(posedge clk) disable iff (!nrst) col_valid |-> credit_cnt != '0
    );

endmodule

`default_nettype wire

//--- hdl/column_mem.sv
`timescale 1ns/10ps
`default_nettype none

`include "pov_defines.svh"

module column_mem (
    input  wire                   clk,
    input  wire                   mem_wr,
    input  wire pov_pkg::slice_t  mem_addr,
    input  wire pov_pkg::column_t mem_wdata,
    input  wire                   rd_en,
    input  wire pov_pkg::slice_t  rd_addr,
    output pov_pkg::column_t      rd_data
);

    import pov_pkg::*;

    // One column per slice of a full turn
    localparam int DEPTH = 2 * `POV_SLICES_HALF;

    // Image storage
    column_t mem [DEPTH];

    // Host write port
    always_ff @(posedge clk) begin
        if (mem_wr) begin
            mem[mem_addr] <= mem_wdata;
        end
    end

    // Synchronous read port with data one cycle after rd_en
    // A read of the address being written returns the old column
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

//--- hdl/pov_config.sv
`timescale 1ns/10ps
`default_nettype none

`include "pov_defines.svh"

module pov_config (
    input  wire                     clk,
    input  wire                     nrst,
    input  wire                     reg_wr,
    input  wire pov_pkg::reg_addr_t reg_addr,
    input  wire pov_pkg::reg_data_t reg_wdata,
    input  wire                     drop,
    input  wire pov_pkg::reg_data_t speed_data,
    output pov_pkg::reg_data_t      reg_rdata,
    output logic                    enable,
    output pov_pkg::slice_t         slice_offset
);

    import pov_pkg::*;

    // Slices lost because the shifter had no room
    reg_data_t dropped_cnt;

    // Control and offset registers
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            enable       <= 1'b0;
            slice_offset <= '0;
        end else if (reg_wr) begin
            if (reg_addr == `POV_REG_CTRL) begin
                enable <= reg_wdata[0];
            end
            if (reg_addr == `POV_REG_OFFSET) begin
                slice_offset <= slice_t'(reg_wdata[$bits(slice_t)-1:0]);
            end
        end
    end

    // Any write to the dropped register clears it, whatever the data
    // A clear wins over a drop in the same cycle
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            dropped_cnt <= '0;
        end else if (reg_wr && reg_addr == `POV_REG_DROPPED) begin
            dropped_cnt <= '0;
        end else if (drop && dropped_cnt != '1) begin
            dropped_cnt <= dropped_cnt + 1'b1;
        end
    end

    // Read mux with speed as a read-only input
    always_comb begin
        case (reg_addr)
            `POV_REG_CTRL:    reg_rdata = reg_data_t'(enable);
            `POV_REG_OFFSET:  reg_rdata = reg_data_t'(slice_offset);
            `POV_REG_DROPPED: reg_rdata = dropped_cnt;
            `POV_REG_SPEED:   reg_rdata = speed_data;
            default:          reg_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/hall_sensor.sv
`timescale 1ns/10ps
`default_nettype none

`include "pov_defines.svh"

module hall_sensor (
    input  wire                clk,
    input  wire                nrst,
    input  wire                hall_1,
    input  wire                hall_2,
    output pov_pkg::slice_t    slice_cnt,
    output logic               position_sync,
    output pov_pkg::reg_data_t speed_data
);

    import pov_pkg::*;

    localparam int HALF_BITS = $clog2(`POV_SLICES_HALF);
    localparam int TURN_BITS = 32;
    // The slice period is the half-turn length divided by the slice count
    localparam int PERIOD_BITS = TURN_BITS - HALF_BITS;

    // HALFTURN1 follows a hall_1 trigger and HALFTURN2 a hall_2 trigger
    typedef enum logic {HALFTURN1, HALFTURN2} half_turn_t;

    half_turn_t             half_turn_state;
    logic                   top;
    logic                   guard;
    logic                   top_set;
    logic [TURN_BITS-1:0]   turn_cnt;
    logic [PERIOD_BITS-1:0] slice_period;
    logic [PERIOD_BITS-1:0] slice_cycle_cnt;
    logic [HALF_BITS-1:0]   slice_half_cnt;
    logic [TURN_BITS+1:0]   speed_div;
    reg_data_t              speed_next;

    // A low sensor fires only when the guard is clear
    assign top_set = (~hall_1 | ~hall_2) & ~guard;

    // Guarded edge detector producing the one-cycle top pulse
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            top             <= 1'b0;
            guard           <= 1'b0;
            half_turn_state <= HALFTURN1;
        end else begin
            top <= top_set;
            if (top_set) begin
                guard <= 1'b1;
                // hall_1 wins if both sensors drop together
                half_turn_state <= (~hall_1) ? HALFTURN1 : HALFTURN2;
            end else if (hall_1 & hall_2) begin
                // Both sensors released so the next magnet may fire again
                guard <= 1'b0;
            end
        end
    end

    // Half-turn length, slice period and speed, all taken at each top
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            turn_cnt     <= '0;
            slice_period <= '0;
            speed_data   <= '0;
        end else if (top) begin
            slice_period <= turn_cnt[TURN_BITS-1:HALF_BITS];
            turn_cnt     <= TURN_BITS'(1);
            speed_data   <= speed_next;
        end else if (turn_cnt != '1) begin
            // Saturate when the wheel has stopped
            turn_cnt <= turn_cnt + 1'b1;
        end
    end

    // Two half turns per revolution, hence the doubling of N + 1
    assign speed_div  = ({2'b00, turn_cnt} + 34'd1) << 1;
    assign speed_next = reg_data_t'(34'(`POV_CLOCK_HZ) / speed_div);

    // Slice sync generator
    // The first sync of a half turn comes from top and the others from the period counter
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            position_sync   <= 1'b0;
            slice_cycle_cnt <= '0;
            slice_half_cnt  <= '0;
        end else if (top) begin
            position_sync   <= 1'b1;
            slice_cycle_cnt <= '0;
            slice_half_cnt  <= '0;
        end else if (slice_period != '0 && !top_set
                     && slice_half_cnt != HALF_BITS'(`POV_SLICES_HALF - 1)
                     && slice_cycle_cnt == slice_period - 1'b1) begin
            // A slice sync is held back when a new top is about to start
            position_sync   <= 1'b1;
            slice_cycle_cnt <= '0;
            slice_half_cnt  <= slice_half_cnt + 1'b1;
        end else begin
            position_sync   <= 1'b0;
            slice_cycle_cnt <= slice_cycle_cnt + 1'b1;
        end
    end

    // Second half turn maps onto slices 128 to 255
    assign slice_cnt = slice_t'({half_turn_state == HALFTURN2, slice_half_cnt});

    // The sync of a top and a period sync must never collide with the top itself
    a_sync_not_on_top : assert property (
        @(posedge clk) disable iff (!nrst) !(top && position_sync)
    );

endmodule

`default_nettype wire

//--- hdl/pov_pkg.sv
`default_nettype none

`include "pov_defines.svh"

package pov_pkg;

    // Slice index over a full turn
    // The upper bit tells which half turn the slice belongs to
    typedef logic [$clog2(2 * `POV_SLICES_HALF)-1:0] slice_t;

    // One image column with one bit per LED
    // Bit 15 is shifted out first
    typedef logic [`POV_NUM_LEDS-1:0] column_t;

    // Host register address
    typedef logic [1:0] reg_addr_t;

    // Host register data
    typedef logic [15:0] reg_data_t;

endpackage

`default_nettype wire

//--- hdl/pov_defines.svh
`ifndef POV_DEFINES_SVH
`define POV_DEFINES_SVH

// System clock frequency in Hz, used to turn a half-turn length into a speed
`define POV_CLOCK_HZ 32'd66_000_000

// Each half turn is cut into this many angular slices
`define POV_SLICES_HALF 128

// LEDs on the arm, one pixel bit each
`define POV_NUM_LEDS 16

// Columns buffered in the LED shifter, which is also the starting credit count
`define POV_FIFO_DEPTH 2

// Host register map
`define POV_REG_CTRL    2'd0
`define POV_REG_OFFSET  2'd1
`define POV_REG_DROPPED 2'd2
`define POV_REG_SPEED   2'd3

`endif
